// File: otp_macro_pkg.sv
////////////////////
// OTP macro interface definitions
// Word and address widths, read commands and response error codes
////////////////////

package otp_macro_pkg;

  // Native macro word is one halfword of 16 bits
  parameter int OtpWidth = 16;

  // Halfword address into the macro
  parameter int OtpAddrWidth = 10;

  // Byte to halfword conversion derived from the word width
  parameter int OtpAddrShift = $clog2(OtpWidth / 8);

  // Byte address as used by the partition logic
  parameter int OtpByteAddrWidth = OtpAddrWidth + OtpAddrShift;

  // Read commands accepted by the macro
  typedef enum logic {
    Read,
    ReadRaw
  } otp_cmd_e;

  // Error code returned with every read response
  typedef enum logic [1:0] {
    OtpNoError,
    OtpEccCorrErr,
    OtpEccUncorrErr,
    OtpMacroErr
  } otp_err_e;

endpackage

// File: part_buf_pkg.sv
////////////////////
// Buffered partition definitions
// Block geometry, counter width helper, FSM states and error codes
////////////////////

package part_buf_pkg;

  // One partition block, also the width of the digest
  parameter int BlockWidth = 64;
  parameter int BlockBytes = BlockWidth / 8;

  // Byte offset of a block index within the partition
  parameter int BlockAddrShift = $clog2(BlockBytes);

  // Width of a block index for a partition of n blocks
  function automatic int cnt_width(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Partition control states
  typedef enum logic [2:0] {
    ResetSt,
    InitSt,
    InitWaitSt,
    IdleSt,
    CnstyReadSt,
    CnstyReadWaitSt,
    ErrorSt
  } part_state_e;

  // Partition error code, sticky once latched
  typedef enum logic [2:0] {
    NoError,
    MacroError,
    MacroEccCorrError,
    MacroEccUncorrError,
    CheckFailError,
    FsmStateError
  } part_err_e;

endpackage

// File: part_buf_fsm.sv
////////////////////
// Partition control FSM
// Init reads into the buffer, consistency re-reads, error latching
// and escalation handling
////////////////////

module part_buf_fsm #(
  parameter int unsigned NumBlocks = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    init_req_i,
  input  logic                                    cnsty_chk_req_i,
  input  logic                                    escalate_i,
  input  logic                                    otp_gnt_i,
  input  logic                                    otp_rvalid_i,
  input  logic [part_buf_pkg::BlockWidth-1:0]     otp_rdata_i,
  input  otp_macro_pkg::otp_err_e                 otp_err_i,
  input  logic [part_buf_pkg::cnt_width(NumBlocks)-1:0] cnt_i,
  input  logic [part_buf_pkg::BlockWidth-1:0]     buf_rdata_i,
  output logic                                    otp_req_o,
  output otp_macro_pkg::otp_cmd_e                 otp_cmd_o,
  output logic                                    cnt_clr_o,
  output logic                                    cnt_en_o,
  output logic                                    buf_wr_en_o,
  output logic                                    dout_unlocked_o,
  output logic                                    cnsty_chk_ack_o,
  output part_buf_pkg::part_err_e                 error_o,
  output logic                                    fsm_err_o
);

  localparam int CntWidth = part_buf_pkg::cnt_width(NumBlocks);
  localparam logic [CntWidth-1:0] LastBlock = CntWidth'(NumBlocks - 1);

  part_buf_pkg::part_state_e state_d, state_q;
  part_buf_pkg::part_err_e   error_d, error_q;
  logic                      unlocked_d, unlocked_q;
  logic                      rsp_ok;
  logic                      rsp_corr;

  // Translate a macro error code into the partition error code
  function automatic part_buf_pkg::part_err_e map_err(otp_macro_pkg::otp_err_e err);
    part_buf_pkg::part_err_e res;
    case (err)
      otp_macro_pkg::OtpEccCorrErr:   res = part_buf_pkg::MacroEccCorrError;
      otp_macro_pkg::OtpEccUncorrErr: res = part_buf_pkg::MacroEccUncorrError;
      otp_macro_pkg::OtpMacroErr:     res = part_buf_pkg::MacroError;
      default:                        res = part_buf_pkg::NoError;
    endcase
    return res;
  endfunction

  // Correctable ECC data is still usable
  assign rsp_corr = (otp_err_i == otp_macro_pkg::OtpEccCorrErr);
  assign rsp_ok   = (otp_err_i == otp_macro_pkg::OtpNoError) || rsp_corr;

  // Only ECC checked reads are issued
  assign otp_cmd_o = otp_macro_pkg::Read;

  ////////////////////
  // Next state logic
  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    unlocked_d      = unlocked_q;
    otp_req_o       = 1'b0;
    cnt_clr_o       = 1'b0;
    cnt_en_o        = 1'b0;
    buf_wr_en_o     = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the one-time init pulse
      part_buf_pkg::ResetSt: begin
        if (init_req_i) begin
          cnt_clr_o = 1'b1;
          state_d   = part_buf_pkg::InitSt;
        end
      end
      // Hold the request until the macro grants it
      part_buf_pkg::InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = part_buf_pkg::InitWaitSt;
        end
      end
      // Store the block, then read the next one or unlock
      part_buf_pkg::InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (rsp_ok) begin
            buf_wr_en_o = 1'b1;
            if (cnt_i == LastBlock) begin
              unlocked_d = 1'b1;
              state_d    = part_buf_pkg::IdleSt;
            end else begin
              cnt_en_o = 1'b1;
              state_d  = part_buf_pkg::InitSt;
            end
            if (rsp_corr) begin
              error_d = part_buf_pkg::MacroEccCorrError;
            end
          end else begin
            error_d = map_err(otp_err_i);
            state_d = part_buf_pkg::ErrorSt;
          end
        end
      end
      // Start a consistency check from block 0
      part_buf_pkg::IdleSt: begin
        if (cnsty_chk_req_i) begin
          cnt_clr_o = 1'b1;
          state_d   = part_buf_pkg::CnstyReadSt;
        end
      end
      part_buf_pkg::CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = part_buf_pkg::CnstyReadWaitSt;
        end
      end
      // Compare the re-read block against the buffered copy
      part_buf_pkg::CnstyReadWaitSt: begin
        if (otp_rvalid_i) begin
          if (!rsp_ok) begin
            error_d         = map_err(otp_err_i);
            cnsty_chk_ack_o = 1'b1;
            state_d         = part_buf_pkg::ErrorSt;
          end else if (otp_rdata_i != buf_rdata_i) begin
            error_d         = part_buf_pkg::CheckFailError;
            cnsty_chk_ack_o = 1'b1;
            state_d         = part_buf_pkg::ErrorSt;
          end else begin
            if (rsp_corr) begin
              error_d = part_buf_pkg::MacroEccCorrError;
            end
            if (cnt_i == LastBlock) begin
              cnsty_chk_ack_o = 1'b1;
              state_d         = part_buf_pkg::IdleSt;
            end else begin
              cnt_en_o = 1'b1;
              state_d  = part_buf_pkg::CnstyReadSt;
            end
          end
        end
      end
      // Terminal state, output locked and checks answered at once
      part_buf_pkg::ErrorSt: begin
        unlocked_d = 1'b0;
        if (error_q == part_buf_pkg::NoError) begin
          error_d = part_buf_pkg::FsmStateError;
        end
        cnsty_chk_ack_o = cnsty_chk_req_i;
      end
      // Illegal state encoding
      default: begin
        state_d   = part_buf_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything, pulse only on entry
    if (escalate_i && state_q != part_buf_pkg::ErrorSt) begin
      state_d   = part_buf_pkg::ErrorSt;
      error_d   = part_buf_pkg::FsmStateError;
      fsm_err_o = 1'b1;
    end
  end

  ////////////////////
  // State registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= part_buf_pkg::ResetSt;
      error_q    <= part_buf_pkg::NoError;
      unlocked_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      unlocked_q <= unlocked_d;
    end
  end

  assign error_o         = error_q;
  assign dout_unlocked_o = unlocked_q;

endmodule

// File: part_addr_gen.sv
////////////////////
// Block counter and OTP address calculation
////////////////////

module part_addr_gen #(
  parameter int unsigned NumBlocks  = 4,
  parameter int unsigned PartOffset = 64
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          cnt_clr_i,
  input  logic                                          cnt_en_i,
  output logic [part_buf_pkg::cnt_width(NumBlocks)-1:0] cnt_o,
  output logic [otp_macro_pkg::OtpAddrWidth-1:0]        otp_addr_o
);

  localparam int CntWidth = part_buf_pkg::cnt_width(NumBlocks);
  localparam int ByteAw   = otp_macro_pkg::OtpByteAddrWidth;

  // Partition base in bytes
  localparam logic [ByteAw-1:0] BaseAddr = ByteAw'(PartOffset);

  logic [CntWidth-1:0] cnt_q;
  logic [ByteAw-1:0]   byte_addr;

  // Clear wins over increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_clr_i) begin
      cnt_q <= '0;
    end else if (cnt_en_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Each block is BlockBytes wide
  assign byte_addr = BaseAddr + (ByteAw'(cnt_q) << part_buf_pkg::BlockAddrShift);

  // Macro is halfword addressed
  assign otp_addr_o = byte_addr[ByteAw-1:otp_macro_pkg::OtpAddrShift];

  assign cnt_o = cnt_q;

endmodule

// File: part_buf_regs.sv
////////////////////
// Partition buffer registers
// Block readback, gated data output and digest
////////////////////

module part_buf_regs #(
  parameter int unsigned NumBlocks = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          wr_en_i,
  input  logic [part_buf_pkg::cnt_width(NumBlocks)-1:0] addr_i,
  input  logic [part_buf_pkg::BlockWidth-1:0]           wdata_i,
  input  logic                                          unlocked_i,
  output logic [part_buf_pkg::BlockWidth-1:0]           rdata_o,
  output logic [NumBlocks*part_buf_pkg::BlockWidth-1:0] data_o,
  output logic [part_buf_pkg::BlockWidth-1:0]           digest_o
);

  localparam int Bw = part_buf_pkg::BlockWidth;

  logic [Bw-1:0]           blocks_q [NumBlocks];
  logic [NumBlocks*Bw-1:0] data_flat;

  // One block written per accepted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      blocks_q <= '{default: '0};
    end else if (wr_en_i) begin
      blocks_q[addr_i] <= wdata_i;
    end
  end

  // Block at the counter, used by the consistency compare
  assign rdata_o = blocks_q[addr_i];

  ////////////////////
  // Output packing, block 0 in the low bits
  for (genvar i = 0; i < NumBlocks; i++) begin : gen_flat
    assign data_flat[i*Bw +: Bw] = blocks_q[i];
  end

  // Nothing leaves the buffer before init has finished
  assign data_o = unlocked_i ? data_flat : '0;

  // Digest sits in the last block
  assign digest_o = blocks_q[NumBlocks-1];

endmodule

// File: part_access_ctrl.sv
////////////////////
// Software access lock aggregation
////////////////////

module part_access_ctrl #(
  parameter bit DigestWriteLock = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                unlocked_i,
  input  logic [part_buf_pkg::BlockWidth-1:0] digest_i,
  input  logic                                wr_lock_i,
  input  logic                                rd_lock_i,
  output logic                                wr_lock_o,
  output logic                                rd_lock_o
);

  logic digest_lock;
  logic wr_lock_q, rd_lock_q;

  // Programmed digest freezes the partition contents
  assign digest_lock = DigestWriteLock && (digest_i != '0);

  // Locked out of reset, opened only after a clean init
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_lock_q <= 1'b1;
      rd_lock_q <= 1'b1;
    end else begin
      wr_lock_q <= !unlocked_i || wr_lock_i || digest_lock;
      rd_lock_q <= !unlocked_i || rd_lock_i;
    end
  end

  assign wr_lock_o = wr_lock_q;
  assign rd_lock_o = rd_lock_q;

endmodule

// File: part_buf_top.sv
////////////////////
// Buffered OTP partition top level
// Connects FSM, address generator, buffer and lock logic
////////////////////

module part_buf_top #(
  parameter int unsigned NumBlocks       = 4,
  parameter int unsigned PartOffset      = 64,
  parameter bit          DigestWriteLock = 1'b1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          init_req_i,
  input  logic                                          cnsty_chk_req_i,
  input  logic                                          escalate_i,
  input  logic                                          access_wr_lock_i,
  input  logic                                          access_rd_lock_i,
  output logic                                          init_done_o,
  output logic                                          cnsty_chk_ack_o,
  output part_buf_pkg::part_err_e                       error_o,
  output logic                                          fsm_err_o,
  output logic                                          access_wr_lock_o,
  output logic                                          access_rd_lock_o,
  output logic [NumBlocks*part_buf_pkg::BlockWidth-1:0] data_o,
  output logic [part_buf_pkg::BlockWidth-1:0]           digest_o,
  // OTP macro
  output logic                                          otp_req_o,
  output otp_macro_pkg::otp_cmd_e                       otp_cmd_o,
  output logic [otp_macro_pkg::OtpAddrWidth-1:0]        otp_addr_o,
  input  logic                                          otp_gnt_i,
  input  logic                                          otp_rvalid_i,
  input  logic [part_buf_pkg::BlockWidth-1:0]           otp_rdata_i,
  input  otp_macro_pkg::otp_err_e                       otp_err_i
);

  logic [part_buf_pkg::cnt_width(NumBlocks)-1:0] cnt;
  logic [part_buf_pkg::BlockWidth-1:0]           buf_rdata;
  logic [part_buf_pkg::BlockWidth-1:0]           digest;
  logic cnt_clr, cnt_en, buf_wr_en, dout_unlocked;

  part_buf_fsm #(.NumBlocks(NumBlocks)) u_fsm (
    .clk_i, .rst_ni, .init_req_i, .cnsty_chk_req_i, .escalate_i,
    .otp_gnt_i, .otp_rvalid_i, .otp_rdata_i, .otp_err_i,
    .cnt_i(cnt), .buf_rdata_i(buf_rdata), .otp_req_o, .otp_cmd_o,
    .cnt_clr_o(cnt_clr), .cnt_en_o(cnt_en), .buf_wr_en_o(buf_wr_en),
    .dout_unlocked_o(dout_unlocked), .cnsty_chk_ack_o, .error_o, .fsm_err_o
  );

  part_addr_gen #(.NumBlocks(NumBlocks), .PartOffset(PartOffset)) u_addr_gen (
    .clk_i, .rst_ni, .cnt_clr_i(cnt_clr), .cnt_en_i(cnt_en),
    .cnt_o(cnt), .otp_addr_o
  );

  // Buffer is written straight from the macro response
  part_buf_regs #(.NumBlocks(NumBlocks)) u_regs (
    .clk_i, .rst_ni, .wr_en_i(buf_wr_en), .addr_i(cnt), .wdata_i(otp_rdata_i),
    .unlocked_i(dout_unlocked), .rdata_o(buf_rdata), .data_o, .digest_o(digest)
  );

  part_access_ctrl #(.DigestWriteLock(DigestWriteLock)) u_access (
    .clk_i, .rst_ni, .unlocked_i(dout_unlocked), .digest_i(digest),
    .wr_lock_i(access_wr_lock_i), .rd_lock_i(access_rd_lock_i),
    .wr_lock_o(access_wr_lock_o), .rd_lock_o(access_rd_lock_o)
  );

  // Init is done while the output is unlocked
  assign init_done_o = dout_unlocked;
  assign digest_o    = digest;

endmodule

// File: tb_clk_gen.sv
////////////////////
// Testbench clock and reset generator
////////////////////

module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  initial clk_o = 1'b0;

  // Period of 10 time units
  always #5 clk_o = ~clk_o;

  // Reset held 5 cycles at start and after each request pulse
  always begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
    @(posedge rst_req_i);
  end

endmodule

// File: tb_otp_model.sv
////////////////////
// Behavioral OTP macro
// Random grant and response latency, error injection, block flip
////////////////////

module tb_otp_model (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic [9:0]               addr_i,
  input  otp_macro_pkg::otp_err_e  err_code_i,
  input  int                       err_blk_i,
  input  logic                     flip_i,
  input  int                       flip_blk_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [63:0]              rdata_o,
  output otp_macro_pkg::otp_err_e  err_o
);

  logic [63:0] mem [64];
  int          seed;
  int          gnt_cnt, rsp_cnt, blk;
  bit          pending;

  // Random contents from a fixed seed
  initial begin
    seed = 52;
    for (int i = 0; i < 64; i++) begin
      mem[i] <= {$random(seed), $random(seed)};
    end
    gnt_o <= 1'b0;
    rvalid_o <= 1'b0;
    rdata_o <= '0;
    err_o <= otp_macro_pkg::OtpNoError;
    pending = 1'b0;
    gnt_cnt = 0;
    rsp_cnt = 0;
  end

  // Outputs change on the falling edge only
  always @(negedge clk_i) begin
    gnt_o    <= 1'b0;
    rvalid_o <= 1'b0;
    if (!rst_ni) begin
      pending = 1'b0;
      gnt_cnt = {$random(seed)} % 4;
    end else if (pending) begin
      if (rsp_cnt == 0) begin
        rvalid_o <= 1'b1;
        rdata_o  <= mem[blk];
        err_o    <= (blk == err_blk_i) ? err_code_i : otp_macro_pkg::OtpNoError;
        pending = 1'b0;
      end else begin
        rsp_cnt--;
      end
    end else if (req_i) begin
      if (gnt_cnt == 0) begin
        // Four halfwords per 64 bit block
        gnt_o <= 1'b1;
        blk = (addr_i >> 2) % 64;
        pending = 1'b1;
        rsp_cnt = {$random(seed)} % 4;
        gnt_cnt = {$random(seed)} % 4;
      end else begin
        gnt_cnt--;
      end
    end
  end

  always @(posedge clk_i) begin
    if (flip_i) begin
      mem[flip_blk_i] <= mem[flip_blk_i] ^ 64'h1;
    end
  end

endmodule

// File: part_buf_tb.sv
////////////////////
// Partition buffer testbench
// Table of scenarios applied in a loop, one line per test
////////////////////

module part_buf_tb;

  localparam int NumRows = 8;
  // Partition starts at byte 64 which is model block 8
  localparam int BaseBlk = 64 / part_buf_pkg::BlockBytes;

  logic clk, rst_n, rst_req, init_req, cnsty_req, esc, rd_lock_sw, flip;
  logic init_done, ack, fsm_err, wr_lock, rd_lock, otp_req, gnt, rvalid;
  logic [255:0] data;
  logic [63:0] digest, rdata;
  logic [9:0] addr;
  part_buf_pkg::part_err_e error;
  otp_macro_pkg::otp_cmd_e cmd;
  otp_macro_pkg::otp_err_e otp_err, err_code;
  int err_blk, flip_blk, row_err, n_ok, n_bad;
  // Acknowledge cycles seen in the current row
  int ack_cnt;
  logic [255:0] exp_data;

  ////////////////////
  // Scenario 0 init only, 1 consistency check, 2 escalation
  int scen_t [NumRows] = '{0, 1, 1, 0, 0, 0, 2, 0};
  int eblk_t [NumRows] = '{0, 0, 2, 1, 2, 0, 0, 0};
  logic corrupt_t [NumRows] = '{0, 0, 1, 0, 0, 0, 0, 0};
  logic rdlock_t [NumRows] = '{0, 0, 0, 0, 0, 0, 0, 1};
  logic expdone_t [NumRows] = '{1, 1, 0, 1, 0, 0, 0, 1};
  // Expected number of acknowledge cycles
  int expack_t [NumRows] = '{0, 1, 1, 0, 0, 0, 1, 0};
  otp_macro_pkg::otp_err_e err_t [NumRows] = '{
    otp_macro_pkg::OtpNoError, otp_macro_pkg::OtpNoError, otp_macro_pkg::OtpNoError,
    otp_macro_pkg::OtpEccCorrErr, otp_macro_pkg::OtpEccUncorrErr,
    otp_macro_pkg::OtpMacroErr, otp_macro_pkg::OtpNoError, otp_macro_pkg::OtpNoError};
  part_buf_pkg::part_err_e experr_t [NumRows] = '{
    part_buf_pkg::NoError, part_buf_pkg::NoError, part_buf_pkg::CheckFailError,
    part_buf_pkg::MacroEccCorrError, part_buf_pkg::MacroEccUncorrError,
    part_buf_pkg::MacroError, part_buf_pkg::FsmStateError, part_buf_pkg::NoError};

  tb_clk_gen clk_gen_i (.rst_req_i(rst_req), .clk_o(clk), .rst_no(rst_n));

  tb_otp_model otp_model_i (
    .clk_i(clk), .rst_ni(rst_n), .req_i(otp_req), .addr_i(addr), .err_code_i(err_code),
    .err_blk_i(err_blk), .flip_i(flip), .flip_blk_i(flip_blk), .gnt_o(gnt),
    .rvalid_o(rvalid), .rdata_o(rdata), .err_o(otp_err)
  );

  part_buf_top part_buf_top_i (
    .clk_i(clk), .rst_ni(rst_n), .init_req_i(init_req), .cnsty_chk_req_i(cnsty_req),
    .escalate_i(esc), .access_wr_lock_i(1'b0), .access_rd_lock_i(rd_lock_sw),
    .init_done_o(init_done), .cnsty_chk_ack_o(ack), .error_o(error), .fsm_err_o(fsm_err),
    .access_wr_lock_o(wr_lock), .access_rd_lock_o(rd_lock), .data_o(data),
    .digest_o(digest), .otp_req_o(otp_req), .otp_cmd_o(cmd), .otp_addr_o(addr),
    .otp_gnt_i(gnt), .otp_rvalid_i(rvalid), .otp_rdata_i(rdata), .otp_err_i(otp_err)
  );

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      row_err++;
    end
  endtask

  // Init ends on done or on a fatal error code
  function automatic logic cond_met(input int what);
    case (what)
      0: return init_done || (error != part_buf_pkg::NoError &&
                              error != part_buf_pkg::MacroEccCorrError);
      1: return ack;
      default: return rst_n;
    endcase
  endfunction

  // Sample 1 unit after the falling edge
  task automatic wait_for(input int what, input string name);
    int n;
    n = 0;
    #1;
    while (!cond_met(what) && n < 300) begin
      if (what == 0 && data !== '0) begin
        $display("Fail data_o got %h expected 0 before init done", data);
        row_err++;
      end
      @(negedge clk);
      #1;
      n++;
    end
    if (n >= 300) begin
      $display("Timeout while waiting for %s", name);
      row_err++;
    end
  endtask

  // Count acknowledge cycles and watch the command of every request
  always @(posedge clk) begin
    if (ack === 1'b1) begin
      ack_cnt++;
    end
    if (otp_req === 1'b1 && cmd !== otp_macro_pkg::Read) begin
      $display("Fail otp_cmd_o got %h expected %h", cmd, otp_macro_pkg::Read);
      row_err++;
    end
  end

  initial begin
    {rst_req, init_req, cnsty_req, esc, rd_lock_sw, flip} = '0;
    err_code = otp_macro_pkg::OtpNoError;
    err_blk = -1;
    flip_blk = 0;
    n_ok = 0;
    n_bad = 0;
    ack_cnt = 0;
    for (int r = 0; r < NumRows; r++) begin
      row_err = 0;
      ack_cnt = 0;
      @(negedge clk);
      rd_lock_sw = rdlock_t[r];
      err_code = err_t[r];
      err_blk = BaseBlk + eblk_t[r];
      flip_blk = BaseBlk + eblk_t[r];
      rst_req = 1'b1;
      @(negedge clk);
      rst_req = 1'b0;
      wait_for(2, "reset release");
      @(negedge clk);
      #1;
      check("access_wr_lock_o", wr_lock, 1'b1);
      check("access_rd_lock_o", rd_lock, 1'b1);
      check("otp_req_o", otp_req, 1'b0);
      check("init_done_o", init_done, 1'b0);
      check("error_o", error, part_buf_pkg::NoError);
      @(negedge clk);
      init_req = 1'b1;
      @(negedge clk);
      init_req = 1'b0;
      wait_for(0, "end of init");
      repeat (2) @(negedge clk);
      if (init_done) begin
        for (int i = 0; i < 4; i++) begin
          exp_data[i*64 +: 64] = otp_model_i.mem[BaseBlk + i];
        end
        check("data_o", data, exp_data);
        check("digest_o", digest, otp_model_i.mem[BaseBlk + 3]);
      end
      if (scen_t[r] == 1) begin
        if (corrupt_t[r]) begin
          flip = 1'b1;
          @(negedge clk);
          flip = 1'b0;
        end
        @(negedge clk);
        cnsty_req = 1'b1;
        wait_for(1, "consistency acknowledge");
        @(negedge clk);
        cnsty_req = 1'b0;
      end else if (scen_t[r] == 2) begin
        @(negedge clk);
        esc = 1'b1;
        #1;
        check("fsm_err_o", fsm_err, 1'b1);
        @(negedge clk);
        esc = 1'b0;
        cnsty_req = 1'b1;
        #1;
        check("fsm_err_o", fsm_err, 1'b0);
        check("cnsty_chk_ack_o", ack, 1'b1);
        @(negedge clk);
        cnsty_req = 1'b0;
      end
      repeat (2) @(negedge clk);
      #1;
      check("cnsty_chk_ack_o", ack_cnt, expack_t[r]);
      check("error_o", error, experr_t[r]);
      check("init_done_o", init_done, expdone_t[r]);
      check("access_rd_lock_o", rd_lock, !expdone_t[r] || rdlock_t[r]);
      check("access_wr_lock_o", wr_lock,
            !expdone_t[r] || (otp_model_i.mem[BaseBlk + 3] != '0));
      if (!init_done) check("data_o", data, '0);
      // Undo the flip for the following rows
      if (corrupt_t[r]) begin
        @(negedge clk);
        flip = 1'b1;
        @(negedge clk);
        flip = 1'b0;
      end
      if (row_err == 0) begin
        n_ok++;
        $display("Test %0d scenario %0d passed", r, scen_t[r]);
      end else begin
        n_bad++;
        $display("Test %0d scenario %0d failed with %0d errors", r, scen_t[r], row_err);
      end
    end
    $display("Tests passed %0d failed %0d", n_ok, n_bad);
    if (n_bad == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: src.f
otp_macro_pkg.sv
part_buf_pkg.sv
part_buf_fsm.sv
part_addr_gen.sv
part_buf_regs.sv
part_access_ctrl.sv
part_buf_top.sv
tb_clk_gen.sv
tb_otp_model.sv
part_buf_tb.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module part_buf_tb -f src.f -o part_buf_sim \
  && ./obj_dir/part_buf_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
